//--- source/exu_pkg.sv
package exu_pkg;

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;
    localparam int nregs     = 32;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_t;

    typedef enum logic [1:0] {
        imm_i12 = 2'd0,
        imm_u20 = 2'd1,
        imm_j20 = 2'd2,
        imm_u5  = 2'd3
    } imm_kind_t;

    typedef enum logic [1:0] {
        a_rs1  = 2'd0,
        a_pc   = 2'd1,
        a_zero = 2'd2
    } a_sel_t;

    typedef enum logic [1:0] {
        b_imm  = 2'd0,
        b_rs2  = 2'd1,
        b_csr  = 2'd2,
        b_zero = 2'd3
    } b_sel_t;

    // Decoded micro-op as it arrives from decode
    typedef struct packed {
        logic [xlen-1:0]      pc;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      imm;
        logic [xlen-1:0]      csr_value;
        imm_kind_t            imm_kind;
        alu_op_t              alu_op;
        logic                 inv;
        a_sel_t               a_sel;
        b_sel_t               b_sel;
        logic                 rf_wen;
        logic                 mem_wen;
        logic                 mem_ren;
        logic                 jump;
        logic                 branch;
        logic [2:0]           funct3;
    } issue_uop_t;

    // Source indices replaced by the values read
    typedef struct packed {
        logic [xlen-1:0]      pc;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      imm;
        logic [xlen-1:0]      csr_value;
        logic [xlen-1:0]      rs1_value;
        logic [xlen-1:0]      rs2_value;
        imm_kind_t            imm_kind;
        alu_op_t              alu_op;
        logic                 inv;
        a_sel_t               a_sel;
        b_sel_t               b_sel;
        logic                 rf_wen;
        logic                 mem_wen;
        logic                 mem_ren;
        logic                 jump;
        logic                 branch;
        logic [2:0]           funct3;
    } ex_op_t;

    typedef struct packed {
        logic [xlen-1:0]      pc;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      result;
        logic [xlen-1:0]      rs2_value;
        logic                 rf_wen;
        logic                 mem_wen;
        logic                 mem_ren;
        logic                 jump;
        logic                 branch;
        logic [2:0]           funct3;
    } wb_op_t;

endpackage

//--- source/pipe_slot.sv
`timescale 1ns/1ps

module pipe_slot #(
    parameter type payload_t = logic [31:0],
    parameter bit  has_flush = 1'b0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    logic     kill;
    payload_t data_q;

    assign kill = has_flush && flush;

    // Refill in the same cycle the entry leaves
    assign in_ready  = (!full || out_ready) && !kill;
    // A flushed entry must not move on to the next stage
    assign out_valid = full && !kill;
    assign out_data  = data_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (kill) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps

module reg_file import exu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [reg_idx_w-1:0] rs1,
    input  logic [reg_idx_w-1:0] rs2,
    output logic [xlen-1:0]      rs1_value,
    output logic [xlen-1:0]      rs2_value,
    input  logic                 wen,
    input  logic [reg_idx_w-1:0] rd,
    input  logic [xlen-1:0]      wdata
);

    logic [xlen-1:0] regs [nregs];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 always reads as zero
    assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- source/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch import exu_pkg::*; (
    input  logic            in_valid,
    output logic            in_ready,
    input  issue_uop_t      in_uop,
    input  logic [xlen-1:0] rs1_value,
    input  logic [xlen-1:0] rs2_value,
    input  logic            ex_busy,
    input  ex_op_t          ex_op,
    input  logic            wb_busy,
    input  wb_op_t          wb_op,
    input  logic            flush,
    output logic            out_valid,
    input  logic            out_ready,
    output ex_op_t          out_op
);

    logic hazard;
    logic stall;

    // In-flight writer of one of our sources
    function automatic logic raw_hit(input logic busy, input logic wen,
                                     input logic [reg_idx_w-1:0] rd,
                                     input issue_uop_t uop);
        return busy && wen && (rd != '0) && (rd == uop.rs1 || rd == uop.rs2);
    endfunction

    assign hazard = raw_hit(ex_busy, ex_op.rf_wen, ex_op.rd, in_uop) ||
                    raw_hit(wb_busy, wb_op.rf_wen, wb_op.rd, in_uop);
    assign stall  = hazard || flush;

    assign out_valid = in_valid && !stall;
    assign in_ready  = out_ready && !stall;

    always_comb begin
        out_op.pc        = in_uop.pc;
        out_op.rd        = in_uop.rd;
        out_op.imm       = in_uop.imm;
        out_op.csr_value = in_uop.csr_value;
        out_op.rs1_value = rs1_value;
        out_op.rs2_value = rs2_value;
        out_op.imm_kind  = in_uop.imm_kind;
        out_op.alu_op    = in_uop.alu_op;
        out_op.inv       = in_uop.inv;
        out_op.a_sel     = in_uop.a_sel;
        out_op.b_sel     = in_uop.b_sel;
        out_op.rf_wen    = in_uop.rf_wen;
        out_op.mem_wen   = in_uop.mem_wen;
        out_op.mem_ren   = in_uop.mem_ren;
        out_op.jump      = in_uop.jump;
        out_op.branch    = in_uop.branch;
        out_op.funct3    = in_uop.funct3;
    end

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu import exu_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_t         op,
    output logic [xlen-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            end
            alu_sltu: begin
                result = {{(xlen-1){1'b0}}, a < b};
            end
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            // Arithmetic shift keeps the sign bit
            alu_sra:    result = $unsigned($signed(a) >>> shamt);
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

endmodule

//--- source/exu.sv
`timescale 1ns/1ps

module exu import exu_pkg::*; (
    input  logic   in_valid,
    output logic   in_ready,
    input  ex_op_t in_op,
    output logic   out_valid,
    input  logic   out_ready,
    output wb_op_t out_op
);

    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_res;

    // Purely combinational stage
    assign out_valid = in_valid;
    assign in_ready  = out_ready;

    always_comb begin
        case (in_op.imm_kind)
            imm_i12: imm_ext = {{(xlen-12){in_op.imm[11]}}, in_op.imm[11:0]};
            imm_u20: imm_ext = {in_op.imm[19:0], 12'b0};
            // Jump offset counts halfwords
            imm_j20: imm_ext = {{(xlen-21){in_op.imm[19]}}, in_op.imm[19:0], 1'b0};
            imm_u5:  imm_ext = {{(xlen-5){1'b0}}, in_op.imm[4:0]};
            default: imm_ext = '0;
        endcase
    end

    always_comb begin
        case (in_op.a_sel)
            a_rs1:   op_a = in_op.rs1_value;
            a_pc:    op_a = in_op.pc;
            default: op_a = '0;
        endcase
    end

    always_comb begin
        case (in_op.b_sel)
            b_imm:   op_b = imm_ext;
            b_rs2:   op_b = in_op.rs2_value;
            b_csr:   op_b = in_op.csr_value;
            default: op_b = '0;
        endcase
    end

    alu alu0 (
        .a      (op_a),
        .b      (op_b),
        .op     (in_op.alu_op),
        .result (alu_res)
    );

    always_comb begin
        out_op.pc        = in_op.pc;
        out_op.rd        = in_op.rd;
        out_op.result    = alu_res ^ {{(xlen-1){1'b0}}, in_op.inv};
        out_op.rs2_value = in_op.rs2_value;
        out_op.rf_wen    = in_op.rf_wen;
        out_op.mem_wen   = in_op.mem_wen;
        out_op.mem_ren   = in_op.mem_ren;
        out_op.jump      = in_op.jump;
        out_op.branch    = in_op.branch;
        out_op.funct3    = in_op.funct3;
    end

endmodule

//--- source/exu_pipe_top.sv
`timescale 1ns/1ps

module exu_pipe_top import exu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    input  logic       in_valid,
    output logic       in_ready,
    input  issue_uop_t in_uop,
    output logic       out_valid,
    input  logic       out_ready,
    output wb_op_t     out
);

    logic [xlen-1:0] rs1_value;
    logic [xlen-1:0] rs2_value;
    logic            rf_wen;

    logic            of_valid;
    logic            of_ready;
    ex_op_t          of_op;

    logic            ex_valid;
    logic            ex_ready;
    ex_op_t          ex_op;

    logic            exu_valid;
    logic            exu_ready;
    wb_op_t          exu_op;

    // Retire into the register file when the result is taken
    assign rf_wen = out_valid && out_ready && out.rf_wen && (out.rd != '0);

    reg_file rf0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1       (in_uop.rs1),
        .rs2       (in_uop.rs2),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .wen       (rf_wen),
        .rd        (out.rd),
        .wdata     (out.result)
    );

    operand_fetch of0 (
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_uop    (in_uop),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .ex_busy   (ex_valid),
        .ex_op     (ex_op),
        .wb_busy   (out_valid),
        .wb_op     (out),
        .flush     (flush),
        .out_valid (of_valid),
        .out_ready (of_ready),
        .out_op    (of_op)
    );

    pipe_slot #(
        .payload_t (ex_op_t),
        .has_flush (1'b1)
    ) ex_slot (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (of_valid),
        .in_ready  (of_ready),
        .in_data   (of_op),
        .out_valid (ex_valid),
        .out_ready (ex_ready),
        .out_data  (ex_op)
    );

    exu exu0 (
        .in_valid  (ex_valid),
        .in_ready  (ex_ready),
        .in_op     (ex_op),
        .out_valid (exu_valid),
        .out_ready (exu_ready),
        .out_op    (exu_op)
    );

    pipe_slot #(
        .payload_t (wb_op_t),
        .has_flush (1'b0)
    ) wb_slot (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (1'b0),
        .in_valid  (exu_valid),
        .in_ready  (exu_ready),
        .in_data   (exu_op),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out)
    );

endmodule

//--- dv/exu_properties.sv
`timescale 1ns/1ps

module exu_properties import exu_pkg::*; (
    input logic   clk,
    input logic   rst_n,
    input logic   flush,
    input logic   in_ready,
    input logic   out_valid,
    input logic   out_ready,
    input wb_op_t out
);

    // Output slot is empty right after reset
    out_empty_after_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // Stalled result holds its value
    out_stable_when_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out))
        else $error("out changed while stalled");

    no_accept_during_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush |-> !in_ready)
        else $error("in_ready high during flush");

endmodule

bind exu_pipe_top exu_properties props0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out       (out)
);

//--- dv/exu_tb.sv
`timescale 1ns/1ps

module exu_tb import exu_pkg::*; ;

    typedef struct {
        string           name;
        issue_uop_t      uop;
        logic [xlen-1:0] exp;
        bit              dropped;
        bit              bp;
    } row_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       flush;
    logic       in_valid;
    logic       in_ready;
    issue_uop_t in_uop;
    logic       out_valid;
    logic       out_ready;
    wb_op_t     out;

    row_t rows[$];
    int   exp_q[$];
    bit   bp_mode;
    int   full_seen;
    int   errors;
    int   waited;

    exu_pipe_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_uop    (in_uop),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out)
    );

    always #50 clk = ~clk;

    task automatic check(input string name, input logic [xlen-1:0] exp,
                         input logic [xlen-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    // Random back-pressure only in the rows that ask for it
    task automatic drive_out_ready();
        out_ready = bp_mode ? 1'($urandom & 1) : 1'b1;
    endtask

    task automatic add_row(input string name, input alu_op_t op, input int rd,
                           input int rs1, input int rs2, input logic [xlen-1:0] imm,
                           input imm_kind_t kind, input a_sel_t a, input b_sel_t b,
                           input logic [xlen-1:0] exp);
        row_t r;
        r = '{name: name, uop: '0, exp: exp, dropped: 1'b0, bp: 1'b0};
        r.uop.rd       = rd[4:0];
        r.uop.rs1      = rs1[4:0];
        r.uop.rs2      = rs2[4:0];
        r.uop.imm      = imm;
        r.uop.imm_kind = kind;
        r.uop.alu_op   = op;
        r.uop.a_sel    = a;
        r.uop.b_sel    = b;
        r.uop.rf_wen   = 1'b1;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row("reset_add", alu_add, 1, 0, 0, 32'h123, imm_i12, a_rs1, b_imm, 32'h123);
        add_row("load_x2", alu_pass_b, 2, 0, 0, 32'h805, imm_i12, a_rs1, b_imm, 32'hffff_f805);
        add_row("add", alu_add, 4, 1, 2, 0, imm_i12, a_rs1, b_rs2, 32'hffff_f928);
        add_row("sub", alu_sub, 5, 1, 2, 0, imm_i12, a_rs1, b_rs2, 32'h0000_091e);
        add_row("sll", alu_sll, 6, 1, 2, 0, imm_i12, a_rs1, b_rs2, 32'h0000_2460);
        add_row("slt", alu_slt, 7, 1, 2, 0, imm_i12, a_rs1, b_rs2, 32'h0);
        add_row("slt_inv", alu_slt, 8, 1, 2, 0, imm_i12, a_rs1, b_rs2, 32'h1);
        rows[rows.size()-1].uop.inv = 1'b1;
        add_row("sltu", alu_sltu, 9, 1, 2, 0, imm_i12, a_rs1, b_rs2, 32'h1);
        add_row("xor", alu_xor, 10, 1, 2, 0, imm_i12, a_rs1, b_rs2, 32'hffff_f926);
        add_row("srl", alu_srl, 11, 2, 1, 0, imm_i12, a_rs1, b_rs2, 32'h1fff_ff00);
        add_row("sra", alu_sra, 12, 2, 1, 0, imm_i12, a_rs1, b_rs2, 32'hffff_ff00);
        add_row("or", alu_or, 13, 1, 2, 0, imm_i12, a_rs1, b_rs2, 32'hffff_f927);
        add_row("and", alu_and, 3, 1, 2, 0, imm_i12, a_rs1, b_rs2, 32'h1);
        add_row("pc_j20", alu_add, 14, 0, 0, 32'hffff0, imm_j20, a_pc, b_imm, 32'h0fe0);
        rows[rows.size()-1].uop.pc = 32'h1000;
        rows[rows.size()-1].uop.jump = 1'b1;
        add_row("zero_u20", alu_add, 15, 0, 0, 32'habcde, imm_u20, a_zero, b_imm, 32'habcd_e000);
        add_row("imm_u5", alu_add, 16, 1, 0, 32'h3f, imm_u5, a_rs1, b_imm, 32'h142);
        add_row("csr", alu_add, 17, 0, 0, 0, imm_i12, a_zero, b_csr, 32'hdead_beef);
        rows[rows.size()-1].uop.csr_value = 32'hdead_beef;
        rows[rows.size()-1].uop.funct3 = 3'd1;
        add_row("x0_dest", alu_pass_b, 0, 0, 0, 32'h55, imm_i12, a_rs1, b_imm, 32'h55);
        add_row("x0_read", alu_add, 18, 0, 0, 0, imm_i12, a_rs1, b_rs2, 32'h0);
        add_row("dep1", alu_add, 19, 1, 0, 32'h1, imm_i12, a_rs1, b_imm, 32'h124);
        add_row("dep2", alu_add, 20, 19, 19, 0, imm_i12, a_rs1, b_rs2, 32'h248);
        add_row("dep3", alu_sub, 21, 20, 1, 0, imm_i12, a_rs1, b_rs2, 32'h125);
        add_row("dep4", alu_xor, 22, 21, 20, 0, imm_i12, a_rs1, b_rs2, 32'h36d);
        for (int i = 0; i < 5; i++) begin
            add_row($sformatf("bp%0d", i), alu_pass_b, 23 + i, 0, 0, 32'h11 * (i + 1),
                    imm_i12, a_rs1, b_imm, 32'h11 * (i + 1));
            rows[rows.size()-1].bp = 1'b1;
        end
        add_row("pre_flush", alu_pass_b, 28, 0, 0, 32'h77, imm_i12, a_rs1, b_imm, 32'h77);
        add_row("flushed", alu_pass_b, 28, 0, 0, 32'h99, imm_i12, a_rs1, b_imm, 32'h99);
        rows[rows.size()-1].dropped = 1'b1;
        add_row("post_flush", alu_add, 29, 28, 0, 0, imm_i12, a_rs1, b_rs2, 32'h77);
    endtask

    // Scoreboard on every out transfer
    always @(posedge clk) begin
        int idx;
        if (rst_n && dut0.ex_valid && out_valid && !out_ready) begin
            check("both_full_in_ready", 32'h0, {31'b0, in_ready});
            full_seen++;
        end
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("result arrived with nothing expected");
            end
            idx = exp_q.pop_front();
            check({rows[idx].name, " result"}, rows[idx].exp, out.result);
            check({rows[idx].name, " rd"}, {27'b0, rows[idx].uop.rd}, {27'b0, out.rd});
            check({rows[idx].name, " pc"}, rows[idx].uop.pc, out.pc);
            check({rows[idx].name, " ctrl"},
                  {24'b0, rows[idx].uop.rf_wen, rows[idx].uop.mem_wen,
                   rows[idx].uop.mem_ren, rows[idx].uop.jump, rows[idx].uop.branch,
                   rows[idx].uop.funct3},
                  {24'b0, out.rf_wen, out.mem_wen, out.mem_ren, out.jump, out.branch,
                   out.funct3});
        end
    end

    initial begin
        void'($urandom(32'h48d9_cc0b));
        rst_n = 1'b0;
        flush = 1'b0;
        in_valid = 1'b0;
        in_uop = '0;
        out_ready = 1'b1;
        bp_mode = 1'b0;
        full_seen = 0;
        errors = 0;
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check("reset out_valid", 32'h0, {31'b0, out_valid});
        check("reset in_ready", 32'h1, {31'b0, in_ready});
        foreach (rows[i]) begin
            @(negedge clk);
            bp_mode = rows[i].bp;
            drive_out_ready();
            in_uop = rows[i].uop;
            in_valid = 1'b1;
            waited = 0;
            #1;
            while (!in_ready) begin
                if (waited == 50) begin
                    abort_run($sformatf("row %s not accepted within 50 cycles", rows[i].name));
                end
                @(negedge clk);
                drive_out_ready();
                #1;
                waited++;
            end
            if (!rows[i].dropped) begin
                exp_q.push_back(i);
            end
            @(posedge clk);
            if (i == 0 || rows[i].dropped) begin
                @(negedge clk);
                drive_out_ready();
                in_valid = 1'b0;
                flush = rows[i].dropped;
                #1;
                if (i == 0) begin
                    check({rows[i].name, " first edge"}, 32'h0, {31'b0, out_valid});
                end else begin
                    check({rows[i].name, " in_ready"}, 32'h0, {31'b0, in_ready});
                end
                @(negedge clk);
                drive_out_ready();
                flush = 1'b0;
                #1;
                if (i == 0) begin
                    check("reset_add latency", 32'h1, {31'b0, out_valid});
                end else begin
                    // Older row has left, the flushed one must not follow
                    check({rows[i].name, " not forwarded"}, 32'h0, {31'b0, out_valid});
                end
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        bp_mode = 1'b0;
        drive_out_ready();
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == 50) begin
                abort_run("no result within 50 cycles");
            end
            @(negedge clk);
            waited++;
        end
        if (full_seen == 0) begin
            abort_run("back-pressure never filled both slots");
        end
        repeat (2) @(negedge clk);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
source/exu_pkg.sv
source/pipe_slot.sv
source/reg_file.sv
source/operand_fetch.sv
source/alu.sv
source/exu.sv
source/exu_pipe_top.sv
dv/exu_properties.sv
dv/exu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= exu_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Failure found in $(LOG)"; exit 1; \
	fi
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
